// ==== Makefile ====
VERILATOR  ?= verilator
FILELIST   := src.f
RTL_TOP    := tcdm_subsys
TB_TOP     := tb_tcdm_subsys
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps
SIM_FLAGS  := --binary --timing --assert --timescale 1ns/1ps
OBJ_DIR    := obj_dir
PASS_MSG   := *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TB_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TB_TOP)
	./$(OBJ_DIR)/$(TB_TOP) | tee /dev/stderr | grep -F -- '$(PASS_MSG)' > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// ==== src.f ====
tcdm_pkg.sv
tcdm_req_fifo.sv
tcdm_bus.sv
tcdm_sram_bank.sv
tcdm_subsys.sv
tb_tcdm_subsys.sv

// ==== tb_tcdm_subsys.sv ====
module tb_tcdm_subsys;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          NrBanks    = tcdm_pkg::NrBanksDefault;
  localparam int          MaxVectors = 64;
  localparam int          VecFields  = 5;
  localparam logic [31:0] MapBase    = 32'h1000;
  localparam logic [31:0] BankBytes  = 32'h100;
  localparam logic [31:0] RandSeed   = 32'hc8afe5a6;
  localparam logic [31:0] NoEntry    = 32'hffff_ffff;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 req;
  tcdm_pkg::tcdm_req_t  req_data;
  logic                 gnt;
  logic [31:0]          cfg_addr_start [NrBanks];
  logic [31:0]          cfg_addr_end   [NrBanks];
  tcdm_pkg::tcdm_rsp_t  rsp;

  // flat vector storage with VecFields words per transaction
  logic [31:0]          vec_mem [MaxVectors*VecFields];
  // byte-wide reference memory keyed by byte address
  logic [7:0]           ref_mem [logic [31:0]];
  tcdm_pkg::tcdm_rsp_t  exp_q [$];
  int                   sent_count;
  int                   rsp_count;
  int                   wd_cycles;

  tcdm_subsys dut0 (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req            (req),
    .req_data       (req_data),
    .gnt            (gnt),
    .cfg_addr_start (cfg_addr_start),
    .cfg_addr_end   (cfg_addr_end),
    .rsp            (rsp)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic stop_on_failure(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      stop_on_failure($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  // queues the expected response and updates the model on writes
  task automatic predict(input logic we, input logic [3:0] be, input logic [31:0] addr,
                         input logic [31:0] wdata);
    tcdm_pkg::tcdm_rsp_t exp;
    logic [31:0]         base;
    logic                mapped;
    base   = {addr[31:2], 2'b00};
    mapped = 1'b0;
    for (int i = 0; i < NrBanks; i++) begin
      if ((addr >= cfg_addr_start[i]) && (addr < cfg_addr_end[i])) begin
        mapped = 1'b1;
      end
    end
    exp.valid = 1'b1;
    exp.err   = !mapped;
    exp.rdata = '0;
    if (mapped && we) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
          ref_mem[base + 32'(b)] = wdata[b*8 +: 8];
        end
      end
    end else if (mapped) begin
      for (int b = 0; b < 4; b++) begin
        if (!ref_mem.exists(base + 32'(b))) begin
          stop_on_failure($sformatf("vector reads address %08h before any write to it", addr));
        end
        exp.rdata[b*8 +: 8] = ref_mem[base + 32'(b)];
      end
    end
    exp_q.push_back(exp);
  endtask

  // response monitor samples rsp on the falling edge where it is stable
  always @(negedge clk_i) begin
    if (rst_ni && rsp.valid) begin
      if (exp_q.size() == 0) begin
        stop_on_failure("a response arrived with no request outstanding");
      end else begin
        tcdm_pkg::tcdm_rsp_t exp;
        exp = exp_q.pop_front();
        check_value("rsp.err", 32'(rsp.err), 32'(exp.err));
        check_value("rsp.rdata", rsp.rdata, exp.rdata);
        rsp_count++;
      end
    end
  end

  // watchdog armed once the vector count is known
  initial begin
    wait (wd_cycles != 0);
    repeat (wd_cycles) @(posedge clk_i);
    stop_on_failure($sformatf("timeout: the run did not finish within %0d cycles", wd_cycles));
  end

  initial begin
    int nvec;
    int max_idle;
    int idle;
    int gap;
    int k;
    sent_count = 0;
    rsp_count  = 0;
    wd_cycles  = 0;
    rst_ni     = 1'b0;
    req        = 1'b0;
    req_data   = '0;
    for (int i = 0; i < NrBanks; i++) begin
      cfg_addr_start[i] = MapBase + 32'(i) * BankBytes;
      cfg_addr_end[i]   = MapBase + 32'(i + 1) * BankBytes;
    end
    void'($urandom(RandSeed));

    for (int i = 0; i < MaxVectors * VecFields; i++) begin
      vec_mem[i] = NoEntry;
    end
    $readmemh("tcdm_vectors.txt", vec_mem);
    nvec     = 0;
    max_idle = 0;
    while ((nvec < MaxVectors) && (vec_mem[nvec*VecFields] !== NoEntry)) begin
      if (int'(vec_mem[nvec*VecFields + 4]) > max_idle) begin
        max_idle = int'(vec_mem[nvec*VecFields + 4]);
      end
      nvec++;
    end
    if (nvec == 0) begin
      stop_on_failure("the vector file holds no transactions");
    end
    // one extra random idle cycle may follow any gap
    wd_cycles = nvec * (max_idle + 1 + 8) + 100;

    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("gnt", 32'(gnt), 32'h1);
    check_value("rsp.valid", 32'(rsp.valid), 32'h0);

    for (int v = 0; v < nvec; v++) begin
      k              = v * VecFields;
      req            = 1'b1;
      req_data.we    = vec_mem[k][0];
      req_data.be    = vec_mem[k + 1][3:0];
      req_data.addr  = vec_mem[k + 2];
      req_data.wdata = vec_mem[k + 3];
      idle           = int'(vec_mem[k + 4]);
      // hold the request until the buffer has room
      while (!gnt) @(negedge clk_i);
      predict(req_data.we, req_data.be, req_data.addr, req_data.wdata);
      sent_count++;
      @(negedge clk_i);
      gap = idle;
      if (gap > 0) begin
        gap = gap + int'($urandom % 2);
        req = 1'b0;
        repeat (gap) @(negedge clk_i);
      end
    end
    req = 1'b0;

    while (rsp_count != sent_count) @(negedge clk_i);
    // a few quiet cycles to catch stray responses
    repeat (4) @(negedge clk_i);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== tcdm_bus.sv ====
module tcdm_bus #(
  parameter int unsigned NrBanks   = 4,
  parameter int unsigned BankWords = 64
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // request buffer side
  input  logic                                 fifo_valid,
  input  tcdm_pkg::tcdm_req_t                  fifo_req,
  output logic                                 pop,
  // run-time address map, start inclusive, end exclusive
  input  logic [tcdm_pkg::AddrWidth-1:0]       cfg_addr_start [NrBanks],
  input  logic [tcdm_pkg::AddrWidth-1:0]       cfg_addr_end   [NrBanks],
  // bank side
  output logic [NrBanks-1:0]                   bank_sel,
  output tcdm_pkg::bank_req_t                  bank_req,
  input  tcdm_pkg::tcdm_rsp_t                  bank_rsp       [NrBanks],
  // host response
  output tcdm_pkg::tcdm_rsp_t                  rsp
);

  localparam int unsigned SelWidth      = (NrBanks > 1) ? $clog2(NrBanks) : 1;
  localparam int unsigned BankAddrWidth = (BankWords > 1) ? $clog2(BankWords) : 1;

  logic                            hit;
  logic [SelWidth-1:0]             sel_idx;
  logic [tcdm_pkg::AddrWidth-1:0]  offset;
  logic [tcdm_pkg::WordIdxWidth-1:0] offset_words;
  logic                            err_pending_q;
  logic [NrBanks-1:0]              bank_valid;
  tcdm_pkg::tcdm_rsp_t             rsp_d;

  // no device-side stall, so every queued request is taken at once
  assign pop = fifo_valid;

  // range match, the highest matching bank wins
  always_comb begin
    hit     = 1'b0;
    sel_idx = '0;
    for (int i = 0; i < NrBanks; i++) begin
      if ((fifo_req.addr >= cfg_addr_start[i]) && (fifo_req.addr < cfg_addr_end[i])) begin
        hit     = 1'b1;
        sel_idx = SelWidth'(i);
      end
    end
  end

  always_comb begin
    bank_sel = '0;
    if (pop && hit) begin
      bank_sel[sel_idx] = 1'b1;
    end
  end

  // word offset into the selected bank
  assign offset       = fifo_req.addr - cfg_addr_start[sel_idx];
  assign offset_words = offset[tcdm_pkg::AddrWidth-1:tcdm_pkg::ByteOffWidth];

  assign bank_req.we       = fifo_req.we;
  assign bank_req.be       = fifo_req.be;
  assign bank_req.word_idx = tcdm_pkg::WordIdxWidth'(offset_words[BankAddrWidth-1:0]);
  assign bank_req.wdata    = fifo_req.wdata;

  // a miss is answered one cycle later, the same as a bank
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_pending_q <= 1'b0;
    end else begin
      err_pending_q <= pop && !hit;
    end
  end

  // merge bank responses with the decode error
  always_comb begin
    rsp_d.valid = err_pending_q;
    rsp_d.err   = err_pending_q;
    rsp_d.rdata = '0;
    for (int i = 0; i < NrBanks; i++) begin
      bank_valid[i] = bank_rsp[i].valid;
      if (bank_rsp[i].valid) begin
        rsp_d.valid = 1'b1;
        rsp_d.err   = rsp_d.err | bank_rsp[i].err;
        rsp_d.rdata = rsp_d.rdata | bank_rsp[i].rdata;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp <= '0;
    end else begin
      rsp <= rsp_d;
    end
  end

  // the OR merge relies on one bank answering at a time
  one_bank_rsp: assert property (
    @(posedge clk_i) disable iff (!rst_ni) $onehot0(bank_valid)
  ) else $error("more than one bank response valid");

endmodule

// ==== tcdm_pkg.sv ====
package tcdm_pkg;

  // data path widths
  localparam int unsigned DataWidth = 32;
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned BeWidth   = DataWidth / 8;

  // byte offset inside a word, dropped when forming a word index
  localparam int unsigned ByteOffWidth = $clog2(BeWidth);

  // widest word index a bank could ever need; each bank keeps only
  // the low bits that cover its own depth
  localparam int unsigned WordIdxWidth = AddrWidth - ByteOffWidth;

  // default subsystem shape, picked up by the top level
  localparam int unsigned NrBanksDefault   = 4;
  localparam int unsigned BankWordsDefault = 64;
  localparam int unsigned FifoDepthDefault = 4;

  // host request payload; the strobe travels beside it
  typedef struct packed {
    logic                 we;
    logic [BeWidth-1:0]   be;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
  } tcdm_req_t;

  // response returned to the host and by each bank
  typedef struct packed {
    logic                 valid;
    logic                 err;
    logic [DataWidth-1:0] rdata;
  } tcdm_rsp_t;

  // request as a bank sees it after decode
  // word_idx is the word offset from the bank start address
  typedef struct packed {
    logic                    we;
    logic [BeWidth-1:0]      be;
    logic [WordIdxWidth-1:0] word_idx;
    logic [DataWidth-1:0]    wdata;
  } bank_req_t;

endpackage

// ==== tcdm_req_fifo.sv ====
module tcdm_req_fifo #(
  parameter int unsigned FifoDepth = 4
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  // host side
  input  logic                req,
  input  tcdm_pkg::tcdm_req_t req_data,
  output logic                gnt,
  // bus side
  input  logic                pop,
  output logic                fifo_valid,
  output tcdm_pkg::tcdm_req_t fifo_req
);

  localparam int unsigned PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int unsigned CntWidth = $clog2(FifoDepth + 1);

  tcdm_pkg::tcdm_req_t mem_q [FifoDepth];

  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] cnt_q;

  logic push;
  logic pop_ok;

  // host may push whenever there is a free slot
  assign gnt        = (cnt_q != CntWidth'(FifoDepth));
  assign fifo_valid = (cnt_q != '0);
  assign fifo_req   = mem_q[rd_ptr_q];

  assign push   = req && gnt;
  assign pop_ok = pop && fifo_valid;

  // storage, payload only
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= req_data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(FifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(FifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leaves the fill level as is
      case ({push, pop_ok})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // bus must only drain what is actually queued
  pop_needs_data: assert property (
    @(posedge clk_i) disable iff (!rst_ni) pop |-> fifo_valid
  ) else $error("pop while request buffer is empty");

  // fill level stays within the storage across any push/pop sequence
  cnt_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_ni) cnt_q <= CntWidth'(FifoDepth)
  ) else $error("request buffer count exceeds depth");

endmodule

// ==== tcdm_sram_bank.sv ====
module tcdm_sram_bank #(
  parameter int unsigned BankWords = 64
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                sel,
  input  tcdm_pkg::bank_req_t bank_req,
  output tcdm_pkg::tcdm_rsp_t bank_rsp
);

  localparam int unsigned BankAddrWidth = (BankWords > 1) ? $clog2(BankWords) : 1;

  logic [tcdm_pkg::DataWidth-1:0] mem_q [BankWords];

  logic [BankAddrWidth-1:0]       idx;
  logic                           valid_q;
  logic [tcdm_pkg::DataWidth-1:0] rdata_q;

  // only the low bits cover this bank
  assign idx = bank_req.word_idx[BankAddrWidth-1:0];

  // byte-masked write
  always_ff @(posedge clk_i) begin
    if (sel && bank_req.we) begin
      for (int b = 0; b < tcdm_pkg::BeWidth; b++) begin
        if (bank_req.be[b]) begin
          mem_q[idx][b*8 +: 8] <= bank_req.wdata[b*8 +: 8];
        end
      end
    end
  end

  // read data register, writes answer with zero
  always_ff @(posedge clk_i) begin
    if (sel) begin
      rdata_q <= bank_req.we ? '0 : mem_q[idx];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= sel;
    end
  end

  assign bank_rsp.valid = valid_q;
  assign bank_rsp.err   = 1'b0;
  assign bank_rsp.rdata = rdata_q;

endmodule

// ==== tcdm_subsys.sv ====
module tcdm_subsys #(
  parameter int unsigned NrBanks   = tcdm_pkg::NrBanksDefault,
  parameter int unsigned BankWords = tcdm_pkg::BankWordsDefault,
  parameter int unsigned FifoDepth = tcdm_pkg::FifoDepthDefault
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // host request port
  input  logic                           req,
  input  tcdm_pkg::tcdm_req_t            req_data,
  output logic                           gnt,
  // bank address map
  input  logic [tcdm_pkg::AddrWidth-1:0] cfg_addr_start [NrBanks],
  input  logic [tcdm_pkg::AddrWidth-1:0] cfg_addr_end   [NrBanks],
  // host response port
  output tcdm_pkg::tcdm_rsp_t            rsp
);

  logic                fifo_valid;
  tcdm_pkg::tcdm_req_t fifo_req;
  logic                pop;
  logic [NrBanks-1:0]  bank_sel;
  tcdm_pkg::bank_req_t bank_req;
  tcdm_pkg::tcdm_rsp_t bank_rsp [NrBanks];

  tcdm_req_fifo #(
    .FifoDepth (FifoDepth)
  ) req_fifo0 (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req        (req),
    .req_data   (req_data),
    .gnt        (gnt),
    .pop        (pop),
    .fifo_valid (fifo_valid),
    .fifo_req   (fifo_req)
  );

  tcdm_bus #(
    .NrBanks   (NrBanks),
    .BankWords (BankWords)
  ) bus0 (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fifo_valid     (fifo_valid),
    .fifo_req       (fifo_req),
    .pop            (pop),
    .cfg_addr_start (cfg_addr_start),
    .cfg_addr_end   (cfg_addr_end),
    .bank_sel       (bank_sel),
    .bank_req       (bank_req),
    .bank_rsp       (bank_rsp),
    .rsp            (rsp)
  );

  // all banks share the decoded request, each has its own select
  for (genvar i = 0; i < NrBanks; i++) begin : gen_banks
    tcdm_sram_bank #(
      .BankWords (BankWords)
    ) bank (
      .clk_i    (clk_i),
      .rst_ni   (rst_ni),
      .sel      (bank_sel[i]),
      .bank_req (bank_req),
      .bank_rsp (bank_rsp[i])
    );
  end

endmodule

// ==== tcdm_vectors.txt ====
// we be addr wdata idle (all hex), one transaction per line
// map: bank i covers 1000+i*100 up to 1100+i*100, everything else misses
1 f 00001000 a5a50000 0
1 f 000010fc a5a500fc 1
1 f 00001100 b6b60100 0
1 f 000011fc b6b601fc 2
1 f 00001200 c7c70200 0
1 f 000012fc c7c702fc 0
1 f 00001300 d8d80300 1
1 f 000013fc d8d803fc 0
0 0 00001000 00000000 0
0 0 000010fc 00000000 0
0 0 00001100 00000000 1
0 0 000011fc 00000000 0
0 0 00001200 00000000 0
0 0 000012fc 00000000 2
0 0 00001300 00000000 0
0 0 000013fc 00000000 1
1 f 00001040 deadbeef 0
1 3 00001040 00001234 1
1 8 00001040 99000000 0
0 0 00001040 00000000 0
1 f 00001280 01234567 0
1 5 00001280 aabbccdd 0
0 0 00001280 00000000 2
1 f 00000ffc 55555555 0
1 f 00001400 66666666 1
0 0 00000000 00000000 0
1 f 00002000 77777777 0
0 0 000010fc 00000000 0
0 0 00001300 00000000 3
1 f 00001104 10000001 0
1 f 00001204 20000002 0
0 0 00001104 00000000 0
1 f 00001304 30000003 0
0 0 00001204 00000000 0
0 0 00000800 00000000 0
0 0 00001304 00000000 0
0 0 00001040 00000000 0
